//--- project.f
verilog/gpu_pkg.sv
verilog/lane_memory.sv
verilog/mem_arbiter.sv
verilog/matadd_engine.sv
verilog/lane_array.sv
verilog/gpu_sequencer.sv
verilog/gpu_top.sv
test/tb_assertions.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
  -f project.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '^RESULT: PASS$' sim.log && exit 0 || exit 1

//--- test/tb_top.sv
module tb_top;
  import gpu_pkg::*;

  logic clk;
  logic rst_n;
  logic imem_we;
  pc_t imem_addr;
  instr_t imem_wdata;
  logic start;
  logic [PC_W:0] instr_count;
  logic busy;
  logic done;
  logic host_we;
  logic host_re;
  row_t host_addr;
  lane_row_t host_wdata;
  logic host_ready;
  lane_row_t host_rdata;
  logic host_rvalid;

  int data_errors;
  int ctrl_errors;
  int cycle_count = 0;
  // grows with every program that gets generated
  int cycle_limit = 2000;
  logic [31:0] lfsr = 32'hced86c8d;
  instr_t prog [IMEM_DEPTH];
  int prog_len;
  int mat_len;
  logic done_seen;

  gpu_top i_dut (.*);

  tb_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // done is a single-cycle pulse, so it is latched here for the waiting tasks
  always @(posedge clk) begin
    if (done) begin
      done_seen = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // galois LFSR, one step for every bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr ^= 32'h80200003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic instr_t make_instr(input opcode_t op, input int d, input int s0,
                                        input int s1, input int imm);
    return {op, d[4:0], s0[4:0], s1[4:0], imm[10:0]};
  endfunction

  task automatic append(input instr_t ins);
    prog[prog_len] = ins;
    prog_len++;
  endtask

  // random scalar op on registers 0..15, stores land in rows 32..47
  function automatic instr_t random_scalar();
    int pick;
    int d;
    int s0;
    int s1;
    pick = take_bits(3) % 7;
    d = take_bits(4);
    s0 = take_bits(4);
    s1 = take_bits(4);
    case (pick)
      0: return make_instr(OP_ADD, d, s0, s1, 0);
      1: return make_instr(OP_SUB, d, s0, s1, 0);
      2: return make_instr(OP_AND, d, s0, s1, 0);
      3: return make_instr(OP_XOR, d, s0, s1, 0);
      4: return make_instr(OP_ADDI, d, s0, 0, take_bits(11));
      5: return make_instr(OP_LOAD, d, 0, 0, take_bits(6) % 48);
      default: return make_instr(OP_STORE, 0, s0, 0, 32 + take_bits(4));
    endcase
  endfunction

  // mode 0 is scalar, mode 1 pairs each LOAD with a dependent ALU op, mode 2 adds a MATADD
  task automatic gen_program(input int mode);
    int n;
    int d;
    int ba;
    int bb;
    int bc;
    prog_len = 0;
    mat_len = 0;
    if (mode == 2) begin
      // A in rows 0..14, B in 16..30 and C in 48..62, so the ranges never meet
      ba = take_bits(3);
      bb = 16 + take_bits(3);
      bc = 48 + take_bits(3);
      mat_len = take_bits(4) % 9;
      append(make_instr(OP_XOR, 29, 29, 29, 0));
      append(make_instr(OP_ADDI, 29, 29, 0, ba));
      append(make_instr(OP_XOR, 30, 30, 30, 0));
      append(make_instr(OP_ADDI, 30, 30, 0, bb));
      append(make_instr(OP_XOR, 31, 31, 31, 0));
      append(make_instr(OP_ADDI, 31, 31, 0, bc));
      append(make_instr(OP_MATADD, 31, 29, 30, mat_len));
      n = 1 + take_bits(3);
    end else begin
      n = 6 + take_bits(3);
    end
    for (int i = 0; i < n; i++) begin
      if (mode == 1 && i % 2 == 0) begin
        d = take_bits(4);
        append(make_instr(OP_LOAD, d, 0, 0, take_bits(6) % 48));
        append(make_instr(OP_ADD, take_bits(4), d, take_bits(4), 0));
      end else begin
        append(random_scalar());
      end
    end
  endtask

  task automatic host_write(input row_t row, input lane_row_t data);
    host_we = 1'b1;
    host_addr = row;
    host_wdata = data;
    do begin
      @(posedge clk);
    end while (!host_ready);
    #1;
    host_we = 1'b0;
  endtask

  task automatic host_read(input row_t row);
    host_re = 1'b1;
    host_addr = row;
    do begin
      @(posedge clk);
    end while (!host_ready);
    #1;
    host_re = 1'b0;
  endtask

  task automatic readback_all();
    for (int r = 0; r < MEM_ROWS; r++) begin
      host_read(row_t'(r));
    end
  endtask

  task automatic run_program(input int mode);
    gen_program(mode);
    cycle_limit += 3 * prog_len + mat_len + 2;
    for (int i = 0; i < prog_len; i++) begin
      imem_we = 1'b1;
      imem_addr = pc_t'(i);
      imem_wdata = prog[i];
      @(posedge clk);
      #1;
    end
    imem_we = 1'b0;
    done_seen = 1'b0;
    instr_count = prog_len[PC_W:0];
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 0;
    if (mode == 2) begin
      // the read is raised in a cycle where the core holds the memory, so it waits for host_ready
      do begin
        @(posedge clk);
        #1;
      end while (host_ready && !done_seen);
      host_read(row_t'(take_bits(5)));
    end
    while (!done_seen) begin
      @(posedge clk);
    end
    #1;
    readback_all();
  endtask

  initial begin
    rst_n = 1'b0;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    start = 1'b0;
    instr_count = '0;
    host_we = 1'b0;
    host_re = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    done_seen = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int r = 0; r < MEM_ROWS; r++) begin
      host_write(row_t'(r), {take_bits(32), take_bits(32)});
    end
    readback_all();
    run_program(0);
    run_program(1);
    run_program(0);
    for (int k = 0; k < 4; k++) begin
      run_program(2);
    end
    run_program(1);
    repeat (3) @(posedge clk);
    $display("closing: %0d data errors, %0d control errors", data_errors, ctrl_errors);
    if (data_errors == 0 && ctrl_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- test/tb_checker.sv
module tb_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    imem_we,
  input  gpu_pkg::pc_t            imem_addr,
  input  gpu_pkg::instr_t         imem_wdata,
  input  logic                    start,
  input  logic [gpu_pkg::PC_W:0]  instr_count,
  input  logic                    busy,
  input  logic                    done,
  input  logic                    host_we,
  input  logic                    host_re,
  input  gpu_pkg::row_t           host_addr,
  input  gpu_pkg::lane_row_t      host_wdata,
  input  logic                    host_ready,
  input  gpu_pkg::lane_row_t      host_rdata,
  input  logic                    host_rvalid,
  output int                      data_errors,
  output int                      ctrl_errors
);
  import gpu_pkg::*;

  instr_t imem_model [IMEM_DEPTH];
  lane_row_t mem_model [MEM_ROWS];
  word_t regs_model [LANES][NUM_REGS];
  logic rd_pending;
  row_t rd_row;
  logic running;
  logic scalar_only;
  int run_cycles;
  int expected_cycles;
  logic reset_checked;

  initial begin
    data_errors = 0;
    ctrl_errors = 0;
    rd_pending = 1'b0;
    running = 1'b0;
    reset_checked = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs_model[l][r] = '0;
      end
    end
  end

  // executes the whole program in order, as soon as start is seen
  task automatic run_model(input int n);
    instr_t ins;
    int op;
    int d;
    int s0;
    int s1;
    row_t row;
    row_t ba;
    row_t bb;
    row_t bc;
    int len;
    scalar_only = 1'b1;
    for (int pc = 0; pc < n; pc++) begin
      ins = imem_model[pc];
      op = ins[31:26];
      d = ins[25:21];
      s0 = ins[20:16];
      s1 = ins[15:11];
      row = ins[5:0];
      for (int l = 0; l < LANES; l++) begin
        case (op)
          1: regs_model[l][d] = regs_model[l][s0] + regs_model[l][s1];
          2: regs_model[l][d] = regs_model[l][s0] - regs_model[l][s1];
          3: regs_model[l][d] = regs_model[l][s0] & regs_model[l][s1];
          4: regs_model[l][d] = regs_model[l][s0] ^ regs_model[l][s1];
          5: regs_model[l][d] = regs_model[l][s0] + {5'd0, ins[10:0]};
          6: regs_model[l][d] = mem_model[row][l];
          7: mem_model[row][l] = regs_model[l][s0];
          default: ;
        endcase
      end
      if (op == 8) begin
        // bases come from lane 0 and keep only the row bits
        scalar_only = 1'b0;
        ba = regs_model[0][s0][5:0];
        bb = regs_model[0][s1][5:0];
        bc = regs_model[0][d][5:0];
        len = ins[6:0];
        for (int i = 0; i < len; i++) begin
          for (int l = 0; l < LANES; l++) begin
            mem_model[bc + row_t'(i)][l] = mem_model[ba + row_t'(i)][l]
                                           + mem_model[bb + row_t'(i)][l];
          end
        end
      end
    end
  endtask

  task automatic compare_row(input row_t row, input lane_row_t act);
    for (int l = 0; l < LANES; l++) begin
      if (act[l] !== mem_model[row][l]) begin
        $display("** Error at %0t: host_rdata row %0d lane %0d expected %h actual %h",
                 $time, row, l, mem_model[row][l], act[l]);
        data_errors++;
      end
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b actual %b", $time, name, exp, act);
      ctrl_errors++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      rd_pending = 1'b0;
      running = 1'b0;
    end else begin
      if (!reset_checked) begin
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("host_ready", 1'b1, host_ready);
        reset_checked = 1'b1;
      end
      // a read accepted at the previous edge must return now
      if (rd_pending) begin
        if (host_rvalid !== 1'b1) begin
          $display("host_rvalid missing one cycle after the read of row %0d at %0t",
                   rd_row, $time);
          ctrl_errors++;
        end else begin
          compare_row(rd_row, host_rdata);
        end
      end else if (host_rvalid === 1'b1) begin
        $display("host_rvalid pulsed at %0t with no accepted read", $time);
        ctrl_errors++;
      end
      rd_pending = host_re && host_ready;
      rd_row = host_addr;
      if (host_we && host_ready) begin
        mem_model[host_addr] = host_wdata;
      end
      if (imem_we) begin
        imem_model[imem_addr] = imem_wdata;
      end
      if (running) begin
        run_cycles++;
        // busy holds for the whole run and falls in the cycle of done
        check_bit("busy", !done, busy);
        if (done) begin
          if (scalar_only && run_cycles != expected_cycles) begin
            $display("** Error at %0t: done cycle expected %0d actual %0d",
                     $time, expected_cycles, run_cycles);
            ctrl_errors++;
          end
          running = 1'b0;
        end
      end else begin
        check_bit("busy", 1'b0, busy);
        if (done) begin
          $display("done pulsed at %0t while no run was in progress", $time);
          ctrl_errors++;
        end
      end
      if (start && !busy) begin
        run_model(int'(instr_count));
        running = 1'b1;
        run_cycles = 0;
        expected_cycles = 3 * int'(instr_count) + 1;
      end
    end
  end

endmodule

//--- test/tb_assertions.sv
module protocol_assertions (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        eng_req,
  input logic                        lane_exec,
  input logic [gpu_pkg::LANES-1:0]   lane_wr_en,
  input logic                        mat_start,
  input logic                        mat_done
);

  // the sequencer stalls while the engine streams
  a_no_peer_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(eng_req && (lane_exec || (|lane_wr_en))))
    else $error("engine and lanes request the memory in the same cycle");

  a_launch_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    mat_start |-> !eng_req)
    else $error("matrix add launched while the engine is still busy");

  // the engine claims the memory only in the cycle after a launch
  a_req_follows_launch: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(eng_req) |-> $past(mat_start))
    else $error("engine requested the memory without a launch");

  // by the time done pulses the last row has been written
  a_done_releases_memory: assert property (@(posedge clk) disable iff (!rst_n)
    mat_done |-> !eng_req)
    else $error("engine reported done while still holding the memory");

endmodule

bind gpu_top protocol_assertions i_protocol_assertions (
  .clk(clk), .rst_n(rst_n), .eng_req(eng_req), .lane_exec(exec),
  .lane_wr_en(lane_wr_en), .mat_start(mat_start), .mat_done(mat_done)
);

//--- verilog/gpu_top.sv
module gpu_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      imem_we,
  input  gpu_pkg::pc_t              imem_addr,
  input  gpu_pkg::instr_t           imem_wdata,
  input  logic                      start,
  input  logic [gpu_pkg::PC_W:0]    instr_count,
  output logic                      busy,
  output logic                      done,
  input  logic                      host_we,
  input  logic                      host_re,
  input  gpu_pkg::row_t             host_addr,
  input  gpu_pkg::lane_row_t        host_wdata,
  output logic                      host_ready,
  output gpu_pkg::lane_row_t        host_rdata,
  output logic                      host_rvalid
);
  import gpu_pkg::*;

  // decoded instruction broadcast from the sequencer to the lanes
  logic exec;
  logic commit;
  opcode_t opcode;
  reg_idx_t dst;
  reg_idx_t src0;
  reg_idx_t src1;
  logic [IMMD_W-1:0] immd;
  word_t lane0_src0;
  word_t lane0_src1;
  word_t lane0_dst;

  // accelerator launch
  logic mat_start;
  logic mat_done;
  row_t base_a;
  row_t base_b;
  row_t base_c;
  logic [ROW_AW:0] length;

  // lane memory requests
  row_t lane_rd_addr;
  logic [LANES-1:0] lane_wr_en;
  row_t lane_wr_addr;
  lane_row_t lane_wr_data;

  // engine memory requests
  logic eng_req;
  row_t eng_rd_addr_a;
  row_t eng_rd_addr_b;
  logic [LANES-1:0] eng_wr_en;
  row_t eng_wr_addr;
  lane_row_t eng_wr_data;

  // shared memory port after arbitration
  row_t mem_rd_addr_a;
  row_t mem_rd_addr_b;
  lane_row_t mem_rd_data_a;
  lane_row_t mem_rd_data_b;
  logic [LANES-1:0] mem_wr_en;
  row_t mem_wr_addr;
  lane_row_t mem_wr_data;

  gpu_sequencer i_sequencer (
    .clk(clk), .rst_n(rst_n), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .start(start), .instr_count(instr_count),
    .busy(busy), .done(done), .exec(exec), .commit(commit), .opcode(opcode),
    .dst(dst), .src0(src0), .src1(src1), .immd(immd),
    .lane0_src0(lane0_src0), .lane0_src1(lane0_src1), .lane0_dst(lane0_dst),
    .mat_start(mat_start), .base_a(base_a), .base_b(base_b), .base_c(base_c),
    .length(length), .mat_done(mat_done)
  );

  lane_array i_lanes (
    .clk(clk), .rst_n(rst_n), .exec(exec), .commit(commit), .opcode(opcode),
    .dst(dst), .src0(src0), .src1(src1), .immd(immd),
    .lane0_src0(lane0_src0), .lane0_src1(lane0_src1), .lane0_dst(lane0_dst),
    .rd_addr(lane_rd_addr), .rd_data(mem_rd_data_a), .wr_en(lane_wr_en),
    .wr_addr(lane_wr_addr), .wr_data(lane_wr_data)
  );

  matadd_engine i_matadd (
    .clk(clk), .rst_n(rst_n), .start(mat_start), .base_a(base_a), .base_b(base_b),
    .base_c(base_c), .length(length), .done(mat_done),
    .rd_addr_a(eng_rd_addr_a), .rd_addr_b(eng_rd_addr_b),
    .rd_data_a(mem_rd_data_a), .rd_data_b(mem_rd_data_b),
    .wr_en(eng_wr_en), .wr_addr(eng_wr_addr), .wr_data(eng_wr_data), .req(eng_req)
  );

  mem_arbiter i_arbiter (
    .clk(clk), .rst_n(rst_n),
    .eng_req(eng_req), .eng_rd_addr_a(eng_rd_addr_a), .eng_rd_addr_b(eng_rd_addr_b),
    .eng_wr_en(eng_wr_en), .eng_wr_addr(eng_wr_addr), .eng_wr_data(eng_wr_data),
    .lane_exec(exec), .lane_rd_addr(lane_rd_addr), .lane_wr_en(lane_wr_en),
    .lane_wr_addr(lane_wr_addr), .lane_wr_data(lane_wr_data),
    .host_we(host_we), .host_re(host_re), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_ready(host_ready), .host_rdata(host_rdata),
    .host_rvalid(host_rvalid),
    .mem_rd_addr_a(mem_rd_addr_a), .mem_rd_addr_b(mem_rd_addr_b),
    .mem_rd_data_a(mem_rd_data_a), .mem_wr_en(mem_wr_en),
    .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
  );

  lane_memory i_memory (
    .clk(clk), .rd_addr_a(mem_rd_addr_a), .rd_addr_b(mem_rd_addr_b),
    .rd_data_a(mem_rd_data_a), .rd_data_b(mem_rd_data_b), .wr_en(mem_wr_en),
    .wr_addr(mem_wr_addr), .wr_data(mem_wr_data)
  );

endmodule

//--- verilog/gpu_sequencer.sv
module gpu_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       imem_we,
  input  gpu_pkg::pc_t               imem_addr,
  input  gpu_pkg::instr_t            imem_wdata,
  input  logic                       start,
  input  logic [gpu_pkg::PC_W:0]     instr_count,
  output logic                       busy,
  output logic                       done,
  output logic                       exec,
  output logic                       commit,
  output gpu_pkg::opcode_t           opcode,
  output gpu_pkg::reg_idx_t          dst,
  output gpu_pkg::reg_idx_t          src0,
  output gpu_pkg::reg_idx_t          src1,
  output logic [gpu_pkg::IMMD_W-1:0] immd,
  input  gpu_pkg::word_t             lane0_src0,
  input  gpu_pkg::word_t             lane0_src1,
  input  gpu_pkg::word_t             lane0_dst,
  output logic                       mat_start,
  output gpu_pkg::row_t              base_a,
  output gpu_pkg::row_t              base_b,
  output gpu_pkg::row_t              base_c,
  output logic [gpu_pkg::ROW_AW:0]   length,
  input  logic                       mat_done
);
  import gpu_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_COMMIT, S_MAT_WAIT} state_t;

  instr_t imem [IMEM_DEPTH];
  state_t state;
  pc_t pc;
  instr_t instr_q;
  logic [PC_W:0] count_q;
  logic [PC_W:0] pc_next;
  logic last_instr;
  logic is_matadd;

  // the host may load the store at any time, the core only reads it in FETCH
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
    if (state == S_FETCH) begin
      instr_q <= imem[pc];
    end
  end

  // fields stay stable from EXEC until the next FETCH
  assign opcode = opcode_t'(instr_q[OPC_MSB:OPC_LSB]);
  assign dst = instr_q[DST_MSB:DST_LSB];
  assign src0 = instr_q[SRC0_MSB:SRC0_LSB];
  assign src1 = instr_q[SRC1_MSB:SRC1_LSB];
  assign immd = instr_q[IMMD_MSB:IMMD_LSB];

  assign is_matadd = (opcode == OP_MATADD);
  assign pc_next = {1'b0, pc} + 1'b1;
  // true when the instruction in flight is the final one of the run
  assign last_instr = (pc_next == count_q);

  assign exec = (state == S_EXEC) && !is_matadd;
  assign commit = (state == S_COMMIT);
  assign mat_start = (state == S_EXEC) && is_matadd;

  // lane 0 supplies the matrix bases, only the row bits are kept
  assign base_a = lane0_src0[ROW_AW-1:0];
  assign base_b = lane0_src1[ROW_AW-1:0];
  assign base_c = lane0_dst[ROW_AW-1:0];
  assign length = immd[ROW_AW:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      pc <= '0;
      count_q <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            pc <= '0;
            count_q <= instr_count;
            // an empty program finishes straight away
            if (instr_count == '0) begin
              done <= 1'b1;
            end else begin
              busy <= 1'b1;
              state <= S_FETCH;
            end
          end
        end
        S_FETCH: state <= S_EXEC;
        S_EXEC: state <= is_matadd ? S_MAT_WAIT : S_COMMIT;
        S_COMMIT, S_MAT_WAIT: begin
          // scalar ops retire here unconditionally, MATADD waits for the engine
          if (state == S_COMMIT || mat_done) begin
            pc <= pc + 1'b1;
            if (last_instr) begin
              busy <= 1'b0;
              done <= 1'b1;
              state <= S_IDLE;
            end else begin
              state <= S_FETCH;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/lane_array.sv
module lane_array (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          exec,
  input  logic                          commit,
  input  gpu_pkg::opcode_t              opcode,
  input  gpu_pkg::reg_idx_t             dst,
  input  gpu_pkg::reg_idx_t             src0,
  input  gpu_pkg::reg_idx_t             src1,
  input  logic [gpu_pkg::IMMD_W-1:0]    immd,
  output gpu_pkg::word_t                lane0_src0,
  output gpu_pkg::word_t                lane0_src1,
  output gpu_pkg::word_t                lane0_dst,
  output gpu_pkg::row_t                 rd_addr,
  input  gpu_pkg::lane_row_t            rd_data,
  output logic [gpu_pkg::LANES-1:0]     wr_en,
  output gpu_pkg::row_t                 wr_addr,
  output gpu_pkg::lane_row_t            wr_data
);
  import gpu_pkg::*;

  lane_row_t src0_vals;
  lane_row_t src1_vals;
  lane_row_t dst_vals;
  word_t immd_ext;
  logic reg_we;

  // ADDI takes the immediate without sign extension
  assign immd_ext = {{(WORD_W - IMMD_W){1'b0}}, immd};

  // only ops that produce a value touch the register file
  always_comb begin
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LOAD: reg_we = commit;
      default: reg_we = 1'b0;
    endcase
  end

  // LOAD and STORE both address row immd, every lane gets its own word
  assign rd_addr = immd[ROW_AW-1:0];
  assign wr_addr = immd[ROW_AW-1:0];
  assign wr_en = {LANES{exec && (opcode == OP_STORE)}};
  assign wr_data = src0_vals;

  // the matrix launch reads its bases from lane 0
  assign lane0_src0 = src0_vals[0];
  assign lane0_src1 = src1_vals[0];
  assign lane0_dst = dst_vals[0];

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    word_t rf [NUM_REGS];
    word_t op_a;
    word_t op_b;
    word_t result;

    assign op_a = rf[src0];
    assign op_b = rf[src1];
    assign src0_vals[l] = op_a;
    assign src1_vals[l] = op_b;
    assign dst_vals[l] = rf[dst];

    // evaluated in COMMIT, when the read data of a LOAD has returned
    always_comb begin
      case (opcode)
        OP_ADD: result = op_a + op_b;
        OP_SUB: result = op_a - op_b;
        OP_AND: result = op_a & op_b;
        OP_XOR: result = op_a ^ op_b;
        OP_ADDI: result = op_a + immd_ext;
        OP_LOAD: result = rd_data[l];
        default: result = op_a;
      endcase
    end

    // registers start at zero so a program may read one it never wrote
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int r = 0; r < NUM_REGS; r++) begin
          rf[r] <= '0;
        end
      end else if (reg_we) begin
        rf[dst] <= result;
      end
    end
  end

endmodule

//--- verilog/matadd_engine.sv
module matadd_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  gpu_pkg::row_t              base_a,
  input  gpu_pkg::row_t              base_b,
  input  gpu_pkg::row_t              base_c,
  input  logic [gpu_pkg::ROW_AW:0]   length,
  output logic                       done,
  output gpu_pkg::row_t              rd_addr_a,
  output gpu_pkg::row_t              rd_addr_b,
  input  gpu_pkg::lane_row_t         rd_data_a,
  input  gpu_pkg::lane_row_t         rd_data_b,
  output logic [gpu_pkg::LANES-1:0]  wr_en,
  output gpu_pkg::row_t              wr_addr,
  output gpu_pkg::lane_row_t         wr_data,
  output logic                       req
);
  import gpu_pkg::*;

  row_t base_a_q;
  row_t base_b_q;
  row_t base_c_q;
  row_t wr_row;
  logic [ROW_AW:0] len_q;
  logic [ROW_AW:0] rd_idx;
  logic reading;
  logic rd_last;
  logic wr_pending;
  logic wr_last;

  assign rd_last = ((rd_idx + 1'b1) == len_q);
  assign rd_addr_a = base_a_q + rd_idx[ROW_AW-1:0];
  assign rd_addr_b = base_b_q + rd_idx[ROW_AW-1:0];

  // stage 2 writes the row whose data arrives this cycle
  assign wr_en = {LANES{wr_pending}};
  assign wr_addr = wr_row;
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      wr_data[l] = rd_data_a[l] + rd_data_b[l];
    end
  end

  // memory is claimed from the first read to the last write
  assign req = reading || wr_pending;

  always_ff @(posedge clk) begin
    if (start) begin
      base_a_q <= base_a;
      base_b_q <= base_b;
      base_c_q <= base_c;
    end
    wr_row <= base_c_q + rd_idx[ROW_AW-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      len_q <= '0;
      rd_idx <= '0;
      reading <= 1'b0;
      wr_pending <= 1'b0;
      wr_last <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= wr_pending && wr_last;
      wr_pending <= reading;
      wr_last <= reading && rd_last;
      if (start) begin
        len_q <= length;
        rd_idx <= '0;
        reading <= (length != '0);
        // zero rows means nothing to stream, report at once
        if (length == '0) begin
          done <= 1'b1;
        end
      end else if (reading) begin
        rd_idx <= rd_idx + 1'b1;
        if (rd_last) begin
          reading <= 1'b0;
        end
      end
    end
  end

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       eng_req,
  input  gpu_pkg::row_t              eng_rd_addr_a,
  input  gpu_pkg::row_t              eng_rd_addr_b,
  input  logic [gpu_pkg::LANES-1:0]  eng_wr_en,
  input  gpu_pkg::row_t              eng_wr_addr,
  input  gpu_pkg::lane_row_t         eng_wr_data,
  input  logic                       lane_exec,
  input  gpu_pkg::row_t              lane_rd_addr,
  input  logic [gpu_pkg::LANES-1:0]  lane_wr_en,
  input  gpu_pkg::row_t              lane_wr_addr,
  input  gpu_pkg::lane_row_t         lane_wr_data,
  input  logic                       host_we,
  input  logic                       host_re,
  input  gpu_pkg::row_t              host_addr,
  input  gpu_pkg::lane_row_t         host_wdata,
  output logic                       host_ready,
  output gpu_pkg::lane_row_t         host_rdata,
  output logic                       host_rvalid,
  output gpu_pkg::row_t              mem_rd_addr_a,
  output gpu_pkg::row_t              mem_rd_addr_b,
  input  gpu_pkg::lane_row_t         mem_rd_data_a,
  output logic [gpu_pkg::LANES-1:0]  mem_wr_en,
  output gpu_pkg::row_t              mem_wr_addr,
  output gpu_pkg::lane_row_t         mem_wr_data
);
  import gpu_pkg::*;

  logic lane_req;

  // an executing lane op may read or write, so it holds the port for that cycle
  assign lane_req = lane_exec || (|lane_wr_en);
  // the host is served only in cycles nobody else wants
  assign host_ready = !eng_req && !lane_req;

  always_comb begin
    mem_rd_addr_a = host_addr;
    mem_rd_addr_b = '0;
    mem_wr_en = '0;
    mem_wr_addr = host_addr;
    mem_wr_data = host_wdata;
    if (eng_req) begin
      mem_rd_addr_a = eng_rd_addr_a;
      mem_rd_addr_b = eng_rd_addr_b;
      mem_wr_en = eng_wr_en;
      mem_wr_addr = eng_wr_addr;
      mem_wr_data = eng_wr_data;
    end else if (lane_req) begin
      mem_rd_addr_a = lane_rd_addr;
      mem_wr_en = lane_wr_en;
      mem_wr_addr = lane_wr_addr;
      mem_wr_data = lane_wr_data;
    end else if (host_we) begin
      mem_wr_en = {LANES{1'b1}};
    end
  end

  // read data of port A is shared, rvalid marks the cycle it belongs to the host
  assign host_rdata = mem_rd_data_a;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_rvalid <= 1'b0;
    end else begin
      host_rvalid <= host_re && host_ready;
    end
  end

endmodule

//--- verilog/lane_memory.sv
module lane_memory (
  input  logic                       clk,
  input  gpu_pkg::row_t              rd_addr_a,
  input  gpu_pkg::row_t              rd_addr_b,
  output gpu_pkg::lane_row_t         rd_data_a,
  output gpu_pkg::lane_row_t         rd_data_b,
  input  logic [gpu_pkg::LANES-1:0]  wr_en,
  input  gpu_pkg::row_t              wr_addr,
  input  gpu_pkg::lane_row_t         wr_data
);
  import gpu_pkg::*;

  lane_row_t mem [MEM_ROWS];

  // each lane bank has its own write enable within the shared row
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (wr_en[l]) begin
        mem[wr_addr][l] <= wr_data[l];
      end
    end
  end

  // both read ports return data one cycle after the address
  // a read of the row being written sees the old contents
  always_ff @(posedge clk) begin
    rd_data_a <= mem[rd_addr_a];
    rd_data_b <= mem[rd_addr_b];
  end

endmodule

//--- verilog/gpu_pkg.sv
package gpu_pkg;

  // four lanes execute every broadcast instruction in lockstep
  localparam int LANES = 4;
  localparam int WORD_W = 16;
  typedef logic [WORD_W-1:0] word_t;

  // one memory row holds a single word for each lane
  localparam int MEM_ROWS = 64;
  localparam int ROW_AW = $clog2(MEM_ROWS);
  typedef logic [ROW_AW-1:0] row_t;
  // lane l owns bits [l*WORD_W +: WORD_W] of a row
  typedef logic [LANES-1:0][WORD_W-1:0] lane_row_t;

  // per-lane register file
  localparam int NUM_REGS = 32;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // instruction store written by the host before a run
  localparam int IMEM_DEPTH = 32;
  localparam int PC_W = $clog2(IMEM_DEPTH);
  typedef logic [PC_W-1:0] pc_t;
  typedef logic [31:0] instr_t;

  // instruction fields, opcode on top and the immediate in the low bits
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 26;
  localparam int DST_MSB = 25;
  localparam int DST_LSB = 21;
  localparam int SRC0_MSB = 20;
  localparam int SRC0_LSB = 16;
  localparam int SRC1_MSB = 15;
  localparam int SRC1_LSB = 11;
  localparam int IMMD_MSB = 10;
  localparam int IMMD_LSB = 0;
  localparam int IMMD_W = IMMD_MSB - IMMD_LSB + 1;

  typedef enum logic [5:0] {
    OP_NOP    = 6'd0,
    OP_ADD    = 6'd1,
    OP_SUB    = 6'd2,
    OP_AND    = 6'd3,
    OP_XOR    = 6'd4,
    OP_ADDI   = 6'd5,
    OP_LOAD   = 6'd6,
    OP_STORE  = 6'd7,
    OP_MATADD = 6'd8
  } opcode_t;

endpackage
